// ==== mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// byte address into the 64 KB memory map
`define MEM_ADDR_W 16

// a word is two bytes, stored little-endian
`define MEM_DATA_W 16

// number of byte or word units in one fill or copy
`define XFER_COUNT_W 16

// depth of the byte array, one entry per address
`define MEM_BYTES 65536

`endif

// ==== bus_pkg.sv ====
`include "mem_defines.svh"

package bus_pkg;

  // operation presented to the memory unit for a single cycle
  typedef enum logic [1:0] {
    BUS_OP_IDLE,
    BUS_OP_READ,
    BUS_OP_WRITE
  } bus_op_t;

  // access size, a word is two byte accesses
  typedef enum logic {
    BUS_SIZE_BYTE,
    BUS_SIZE_WORD
  } bus_size_t;

  typedef logic [`MEM_ADDR_W-1:0] addr_t;

  // a byte value sits zero-extended in the low half
  typedef logic [`MEM_DATA_W-1:0] data_t;

endpackage

// ==== xfer_pkg.sv ====
`include "mem_defines.svh"

package xfer_pkg;

  // host command encoding
  typedef enum logic [1:0] {
    CMD_READ,
    CMD_WRITE,
    CMD_FILL,
    CMD_COPY
  } cmd_t;

  typedef logic [`XFER_COUNT_W-1:0] count_t;

  // modular sum of the units written by fill and copy
  typedef logic [`MEM_DATA_W-1:0] sum_t;

  // command sequencer states
  typedef enum logic [2:0] {
    IDLE,
    ISSUE_RD,
    WAIT_RD,
    ISSUE_WR,
    WAIT_WR,
    STEP,
    ACK,
    RELEASE
  } ctrl_state_t;

endpackage

// ==== mem_unit.sv ====
`timescale 1ns/10ps
`include "mem_defines.svh"

module mem_unit (
  input  logic               clk,
  input  logic               reset,
  input  bus_pkg::bus_op_t   mem_op,
  input  bus_pkg::bus_size_t mem_size,
  input  bus_pkg::addr_t     mem_addr,
  input  bus_pkg::data_t     mem_wdata,
  output logic               mem_done,
  output bus_pkg::data_t     mem_rdata
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_RD_LO,
    S_RD_HI,
    S_WR_LO,
    S_WR_HI
  } unit_state_t;

  logic [7:0] mem [0:`MEM_BYTES-1];

  unit_state_t        state;
  bus_pkg::addr_t     addr_q;
  bus_pkg::addr_t     addr_hi;
  bus_pkg::data_t     wdata_q;
  bus_pkg::bus_size_t size_q;
  logic [7:0]         lo_q;
  logic               mem_we;
  bus_pkg::addr_t     mem_wa;
  logic [7:0]         mem_wd;

  initial begin
    for (int i = 0; i < `MEM_BYTES; i++) begin
      mem[i] = 8'h00;
    end
  end

  // the high byte of a word wraps around the top of the map
  assign addr_hi = addr_q + 16'd1;

  assign mem_we = (state == S_WR_LO) || (state == S_WR_HI);
  assign mem_wa = (state == S_WR_HI) ? addr_hi : addr_q;
  assign mem_wd = (state == S_WR_HI) ? wdata_q[15:8] : wdata_q[7:0];

  always @(posedge clk) begin
    if (mem_we) begin
      mem[mem_wa] <= mem_wd;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= S_IDLE;
      mem_done <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (mem_op == bus_pkg::BUS_OP_READ) begin
            state <= S_RD_LO;
          end else if (mem_op == bus_pkg::BUS_OP_WRITE) begin
            state <= S_WR_LO;
          end
        end
        S_RD_LO, S_WR_LO: begin
          if (size_q == bus_pkg::BUS_SIZE_WORD) begin
            state <= (state == S_RD_LO) ? S_RD_HI : S_WR_HI;
          end else begin
            mem_done <= 1'b1;
            state    <= S_IDLE;
          end
        end
        S_RD_HI, S_WR_HI: begin
          mem_done <= 1'b1;
          state    <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // request latch and read assembly
  always_ff @(posedge clk) begin
    if (state == S_IDLE && mem_op != bus_pkg::BUS_OP_IDLE) begin
      addr_q  <= mem_addr;
      wdata_q <= mem_wdata;
      size_q  <= mem_size;
    end
    if (state == S_RD_LO) begin
      lo_q <= mem[addr_q];
      if (size_q == bus_pkg::BUS_SIZE_BYTE) begin
        mem_rdata <= {8'h00, mem[addr_q]};
      end
    end
    if (state == S_RD_HI) begin
      mem_rdata <= {mem[addr_hi], lo_q};
    end
  end

  // the controller must wait for mem_done before issuing again
  a_op_only_in_idle: assert property (@(posedge clk) disable iff (reset)
    (state != S_IDLE) |-> (mem_op == bus_pkg::BUS_OP_IDLE));

  a_done_one_cycle: assert property (@(posedge clk) disable iff (reset)
    mem_done |=> !mem_done);

endmodule

// ==== addr_gen.sv ====
`timescale 1ns/10ps

module addr_gen (
  input  logic               clk,
  input  logic               reset,
  input  logic               load,
  input  logic               advance,
  input  bus_pkg::bus_size_t size,
  input  bus_pkg::addr_t     src_start,
  input  bus_pkg::addr_t     dst_start,
  input  xfer_pkg::count_t   count_in,
  output bus_pkg::addr_t     src_addr,
  output bus_pkg::addr_t     dst_addr,
  output logic               remaining_zero
);

  bus_pkg::bus_size_t size_q;
  bus_pkg::addr_t     step;
  xfer_pkg::count_t   remaining;

  assign step = (size_q == bus_pkg::BUS_SIZE_WORD) ? 16'd2 : 16'd1;

  // addresses wrap naturally at 16 bits
  always_ff @(posedge clk) begin
    if (load) begin
      src_addr <= src_start;
      dst_addr <= dst_start;
      size_q   <= size;
    end else if (advance) begin
      src_addr <= src_addr + step;
      dst_addr <= dst_addr + step;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      remaining      <= '0;
      remaining_zero <= 1'b1;
    end else if (load) begin
      remaining      <= count_in;
      remaining_zero <= (count_in == '0);
    end else if (advance) begin
      remaining      <= remaining - 16'd1;
      remaining_zero <= (remaining == 16'd1);
    end
  end

  // the sequencer only steps while units are left
  a_no_advance_at_zero: assert property (@(posedge clk) disable iff (reset)
    advance |-> !remaining_zero);

endmodule

// ==== data_stage.sv ====
`timescale 1ns/10ps

module data_stage (
  input  logic               clk,
  input  logic               reset,
  input  logic               load_host,
  input  logic               capture_read,
  input  logic               sum_clear,
  input  logic               sum_add,
  input  logic               post_read,
  input  logic               post_sum,
  input  bus_pkg::data_t     host_wdata,
  input  bus_pkg::data_t     mem_rdata,
  input  bus_pkg::bus_size_t size,
  output bus_pkg::data_t     hold_data,
  output bus_pkg::data_t     result
);

  bus_pkg::data_t hold_src;
  bus_pkg::data_t hold_next;
  xfer_pkg::sum_t sum;

  assign hold_src = load_host ? host_wdata : mem_rdata;

  // a byte unit only keeps its low half
  assign hold_next = (size == bus_pkg::BUS_SIZE_BYTE) ? {8'h00, hold_src[7:0]} : hold_src;

  always_ff @(posedge clk) begin
    if (load_host || capture_read) begin
      hold_data <= hold_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sum <= '0;
    end else if (sum_clear) begin
      sum <= '0;
    end else if (sum_add) begin
      sum <= sum + hold_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
    end else if (post_read) begin
      result <= mem_rdata;
    end else if (post_sum) begin
      result <= sum;
    end
  end

endmodule

// ==== xfer_ctrl.sv ====
`timescale 1ns/10ps

module xfer_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  logic               cmd_req,
  input  xfer_pkg::cmd_t     cmd,
  input  bus_pkg::bus_size_t cmd_size,
  input  logic               mem_done,
  input  logic               remaining_zero,
  output logic               cmd_ack,
  output bus_pkg::bus_op_t   mem_op,
  output bus_pkg::bus_size_t mem_size,
  output logic               addr_sel_src,
  output logic               load,
  output logic               advance,
  output logic               load_host,
  output logic               capture_read,
  output logic               sum_clear,
  output logic               sum_add,
  output logic               post_read,
  output logic               post_sum
);

  xfer_pkg::ctrl_state_t state;
  xfer_pkg::cmd_t        cmd_q;
  bus_pkg::bus_size_t    size_q;
  logic                  is_copy;
  logic                  multi;

  assign is_copy = (cmd_q == xfer_pkg::CMD_COPY);
  assign multi   = is_copy || (cmd_q == xfer_pkg::CMD_FILL);

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= xfer_pkg::IDLE;
      cmd_q  <= xfer_pkg::CMD_READ;
      size_q <= bus_pkg::BUS_SIZE_BYTE;
    end else begin
      case (state)
        xfer_pkg::IDLE: begin
          if (cmd_req) begin
            cmd_q  <= cmd;
            size_q <= cmd_size;
            case (cmd)
              xfer_pkg::CMD_READ:  state <= xfer_pkg::ISSUE_RD;
              xfer_pkg::CMD_WRITE: state <= xfer_pkg::ISSUE_WR;
              // fill and copy check the count before the first unit
              default:             state <= xfer_pkg::STEP;
            endcase
          end
        end
        xfer_pkg::ISSUE_RD: state <= xfer_pkg::WAIT_RD;
        xfer_pkg::WAIT_RD: begin
          if (mem_done) begin
            state <= is_copy ? xfer_pkg::ISSUE_WR : xfer_pkg::ACK;
          end
        end
        xfer_pkg::ISSUE_WR: state <= xfer_pkg::WAIT_WR;
        xfer_pkg::WAIT_WR: begin
          if (mem_done) begin
            state <= multi ? xfer_pkg::STEP : xfer_pkg::ACK;
          end
        end
        xfer_pkg::STEP: begin
          if (remaining_zero) begin
            state <= xfer_pkg::ACK;
          end else begin
            state <= is_copy ? xfer_pkg::ISSUE_RD : xfer_pkg::ISSUE_WR;
          end
        end
        xfer_pkg::ACK: begin
          if (!cmd_req) begin
            state <= xfer_pkg::RELEASE;
          end
        end
        default: state <= xfer_pkg::IDLE;
      endcase
    end
  end

  assign cmd_ack  = (state == xfer_pkg::ACK);
  assign mem_size = size_q;

  always_comb begin
    mem_op       = bus_pkg::BUS_OP_IDLE;
    addr_sel_src = 1'b0;
    load         = 1'b0;
    advance      = 1'b0;
    load_host    = 1'b0;
    capture_read = 1'b0;
    sum_clear    = 1'b0;
    sum_add      = 1'b0;
    post_read    = 1'b0;
    post_sum     = 1'b0;
    case (state)
      xfer_pkg::IDLE: begin
        load      = cmd_req;
        load_host = cmd_req;
        sum_clear = cmd_req;
      end
      xfer_pkg::ISSUE_RD: begin
        mem_op       = bus_pkg::BUS_OP_READ;
        addr_sel_src = 1'b1;
      end
      xfer_pkg::WAIT_RD: begin
        capture_read = mem_done && is_copy;
        post_read    = mem_done && !is_copy;
      end
      xfer_pkg::ISSUE_WR: mem_op = bus_pkg::BUS_OP_WRITE;
      xfer_pkg::WAIT_WR: begin
        // a single write posts the cleared sum, so its result reads 0
        sum_add  = mem_done && multi;
        advance  = mem_done && multi;
        post_sum = mem_done && !multi;
      end
      xfer_pkg::STEP: post_sum = remaining_zero;
      default: begin
      end
    endcase
  end

  a_ack_held_until_release: assert property (@(posedge clk) disable iff (reset)
    $fell(cmd_ack) |-> $past(!cmd_req));

endmodule

// ==== mem_subsys.sv ====
`timescale 1ns/10ps

module mem_subsys (
  input  logic               clk,
  input  logic               reset,
  input  logic               cmd_req,
  input  xfer_pkg::cmd_t     cmd,
  input  bus_pkg::bus_size_t cmd_size,
  input  bus_pkg::addr_t     src_addr,
  input  bus_pkg::addr_t     dst_addr,
  input  xfer_pkg::count_t   count,
  input  bus_pkg::data_t     wdata,
  output logic               cmd_ack,
  output bus_pkg::data_t     result
);

  bus_pkg::bus_op_t   mem_op;
  bus_pkg::bus_size_t mem_size;
  bus_pkg::addr_t     mem_addr;
  bus_pkg::data_t     mem_rdata;
  bus_pkg::addr_t     gen_src;
  bus_pkg::addr_t     gen_dst;
  bus_pkg::data_t     hold_data;
  xfer_pkg::count_t   unit_count;
  logic               mem_done;
  logic               remaining_zero;
  logic               addr_sel_src;
  logic               load;
  logic               advance;
  logic               load_host;
  logic               capture_read;
  logic               sum_clear;
  logic               sum_add;
  logic               post_read;
  logic               post_sum;

  // single accesses run as a one-unit transfer
  assign unit_count = (cmd == xfer_pkg::CMD_READ || cmd == xfer_pkg::CMD_WRITE) ? 16'd1 : count;

  assign mem_addr = addr_sel_src ? gen_src : gen_dst;

  xfer_ctrl u_xfer_ctrl (
    .clk, .reset, .cmd_req, .cmd, .cmd_size, .mem_done, .remaining_zero,
    .cmd_ack, .mem_op, .mem_size, .addr_sel_src, .load, .advance, .load_host,
    .capture_read, .sum_clear, .sum_add, .post_read, .post_sum
  );

  mem_unit u_mem_unit (
    .clk, .reset, .mem_op, .mem_size, .mem_addr,
    .mem_wdata (hold_data),
    .mem_done, .mem_rdata
  );

  addr_gen u_addr_gen (
    .clk, .reset, .load, .advance,
    .size           (cmd_size),
    .src_start      (src_addr),
    .dst_start      (dst_addr),
    .count_in       (unit_count),
    .src_addr       (gen_src),
    .dst_addr       (gen_dst),
    .remaining_zero
  );

  data_stage u_data_stage (
    .clk, .reset, .load_host, .capture_read, .sum_clear, .sum_add, .post_read, .post_sum,
    .host_wdata (wdata),
    .mem_rdata,
    .size       (cmd_size),
    .hold_data,
    .result
  );

endmodule

// ==== tb_mem_subsys.sv ====
`timescale 1ns/10ps
`include "mem_defines.svh"

module tb_mem_subsys;

  localparam int TIMEOUT_CYCLES = 2000;

  logic               clk;
  logic               reset;
  logic               cmd_req;
  xfer_pkg::cmd_t     cmd;
  bus_pkg::bus_size_t cmd_size;
  bus_pkg::addr_t     src_addr;
  bus_pkg::addr_t     dst_addr;
  xfer_pkg::count_t   count;
  bus_pkg::data_t     wdata;
  logic               cmd_ack;
  bus_pkg::data_t     result;

  logic [7:0]     ref_mem [0:`MEM_BYTES-1];
  logic [31:0]    rng_state;
  bit             kind_q[$];
  bus_pkg::data_t got_q[$];
  bus_pkg::data_t exp_q[$];
  string          tag_q[$];
  int             errors;

  mem_subsys u_mem_subsys (
    .clk, .reset, .cmd_req, .cmd, .cmd_size, .src_addr, .dst_addr, .count, .wdata,
    .cmd_ack, .result
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // a word is little-endian and its high byte wraps past 16'hFFFF
  function automatic bus_pkg::data_t read_model_unit(bus_pkg::addr_t addr,
                                                     bus_pkg::bus_size_t size);
    bus_pkg::addr_t hi;
    hi = addr + 16'd1;
    if (size == bus_pkg::BUS_SIZE_BYTE) return {8'h00, ref_mem[addr]};
    return {ref_mem[hi], ref_mem[addr]};
  endfunction

  function automatic void write_model_unit(bus_pkg::addr_t addr, bus_pkg::bus_size_t size,
                                           bus_pkg::data_t value);
    bus_pkg::addr_t hi;
    hi = addr + 16'd1;
    ref_mem[addr] = value[7:0];
    if (size == bus_pkg::BUS_SIZE_WORD) ref_mem[hi] = value[15:8];
  endfunction

  // applies one command to the model and returns what the host should see
  function automatic bus_pkg::data_t predict_command(xfer_pkg::cmd_t c, bus_pkg::bus_size_t size,
                                                     bus_pkg::addr_t src, bus_pkg::addr_t dst,
                                                     xfer_pkg::count_t n, bus_pkg::data_t wd);
    bus_pkg::addr_t step;
    bus_pkg::addr_t sa;
    bus_pkg::addr_t da;
    bus_pkg::data_t unit_val;
    xfer_pkg::sum_t sum;
    step = (size == bus_pkg::BUS_SIZE_WORD) ? 16'd2 : 16'd1;
    sa = src;
    da = dst;
    sum = '0;
    unit_val = (size == bus_pkg::BUS_SIZE_BYTE) ? {8'h00, wd[7:0]} : wd;
    case (c)
      xfer_pkg::CMD_READ: sum = read_model_unit(src, size);
      xfer_pkg::CMD_WRITE: write_model_unit(dst, size, unit_val);
      default: begin
        // copy goes unit by unit, so an overlapping copy sees its own writes
        for (int i = 0; i < n; i++) begin
          if (c == xfer_pkg::CMD_COPY) unit_val = read_model_unit(sa, size);
          write_model_unit(da, size, unit_val);
          sum += unit_val;
          sa += step;
          da += step;
        end
      end
    endcase
    return sum;
  endfunction

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_data(bus_pkg::data_t got, bus_pkg::data_t exp, string what);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s returned %h, expected %h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_sum(xfer_pkg::sum_t got, xfer_pkg::sum_t exp, string what);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s checksum %h, expected %h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "checksum mismatch");
    end
  endtask

  always @(negedge clk) begin : compare_results
    bit             kind;
    bus_pkg::data_t got;
    bus_pkg::data_t exp;
    string          tag;
    while (kind_q.size() > 0) begin
      kind = kind_q.pop_front();
      got = got_q.pop_front();
      exp = exp_q.pop_front();
      tag = tag_q.pop_front();
      if (kind) check_sum(xfer_pkg::sum_t'(got), xfer_pkg::sum_t'(exp), tag);
      else check_data(got, exp, tag);
    end
  end

  task automatic wait_ack(logic level);
    int cycles;
    cycles = 0;
    while (cmd_ack !== level && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (cmd_ack !== level) begin
      abort_run($sformatf("timeout waiting for cmd_ack to become %0d", level));
    end
  endtask

  task automatic run_command(xfer_pkg::cmd_t c, bus_pkg::bus_size_t size, bus_pkg::addr_t src,
                             bus_pkg::addr_t dst, xfer_pkg::count_t n, bus_pkg::data_t wd,
                             int hold);
    bus_pkg::data_t expected;
    bus_pkg::data_t first;
    string          tag;
    @(negedge clk);
    cmd = c;
    cmd_size = size;
    src_addr = src;
    dst_addr = dst;
    count = n;
    wdata = wd;
    cmd_req = 1'b1;
    expected = predict_command(c, size, src, dst, n, wd);
    tag = $sformatf("%s size %0d src %h dst %h count %0d", c.name(), size, src, dst, n);
    wait_ack(1'b1);
    first = result;
    kind_q.push_back(c == xfer_pkg::CMD_FILL || c == xfer_pkg::CMD_COPY);
    got_q.push_back(first);
    exp_q.push_back(expected);
    tag_q.push_back(tag);
    repeat (hold) begin
      @(negedge clk);
      if (cmd_ack !== 1'b1) abort_run("cmd_ack fell while cmd_req was still high");
      kind_q.push_back(c == xfer_pkg::CMD_FILL || c == xfer_pkg::CMD_COPY);
      got_q.push_back(result);
      exp_q.push_back(expected);
      tag_q.push_back({"held ", tag});
    end
    cmd_req = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic verify_range(bus_pkg::addr_t start, int units, bus_pkg::bus_size_t size);
    bus_pkg::addr_t a;
    a = start;
    for (int i = 0; i < units; i++) begin
      run_command(xfer_pkg::CMD_READ, size, a, 16'h0000, 16'd1, 16'h0000, 0);
      a += (size == bus_pkg::BUS_SIZE_WORD) ? 16'd2 : 16'd1;
    end
  endtask

  initial begin : stimulus
    logic [31:0]       r;
    xfer_pkg::cmd_t    rc;
    bus_pkg::bus_size_t rs;
    int                drain;
    clk = 1'b0;
    reset = 1'b1;
    cmd_req = 1'b0;
    cmd = xfer_pkg::CMD_READ;
    cmd_size = bus_pkg::BUS_SIZE_BYTE;
    src_addr = '0;
    dst_addr = '0;
    count = '0;
    wdata = '0;
    errors = 0;
    rng_state = 32'hde159208;
    for (int i = 0; i < `MEM_BYTES; i++) ref_mem[i] = 8'h00;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    if (cmd_ack !== 1'b0) abort_run("cmd_ack is not low after reset");
    run_command(xfer_pkg::CMD_READ, bus_pkg::BUS_SIZE_BYTE, 16'h0123, 16'h0, 16'd1, 16'h0, 0);

    // single accesses, including a word that wraps to address 0
    run_command(xfer_pkg::CMD_WRITE, bus_pkg::BUS_SIZE_BYTE, 16'h0, 16'h1234, 16'd1, 16'h77A5, 0);
    verify_range(16'h1233, 3, bus_pkg::BUS_SIZE_BYTE);
    run_command(xfer_pkg::CMD_WRITE, bus_pkg::BUS_SIZE_WORD, 16'h0, 16'h2000, 16'd1, 16'hBEEF, 0);
    verify_range(16'h2000, 1, bus_pkg::BUS_SIZE_WORD);
    verify_range(16'h2000, 2, bus_pkg::BUS_SIZE_BYTE);
    run_command(xfer_pkg::CMD_WRITE, bus_pkg::BUS_SIZE_WORD, 16'h0, 16'hFFFF, 16'd1, 16'h1357, 0);
    verify_range(16'hFFFF, 1, bus_pkg::BUS_SIZE_WORD);
    verify_range(16'h0000, 1, bus_pkg::BUS_SIZE_BYTE);

    run_command(xfer_pkg::CMD_FILL, bus_pkg::BUS_SIZE_BYTE, 16'h0, 16'h3000, 16'd20, 16'h12C3, 0);
    verify_range(16'h2FFF, 22, bus_pkg::BUS_SIZE_BYTE);
    run_command(xfer_pkg::CMD_FILL, bus_pkg::BUS_SIZE_WORD, 16'h0, 16'hFFF0, 16'd12, 16'hABCD, 0);
    verify_range(16'hFFEE, 14, bus_pkg::BUS_SIZE_WORD);

    run_command(xfer_pkg::CMD_COPY, bus_pkg::BUS_SIZE_BYTE, 16'h3000, 16'h3100, 16'd8, 16'h0, 0);
    run_command(xfer_pkg::CMD_WRITE, bus_pkg::BUS_SIZE_WORD, 16'h0, 16'h3002, 16'd1, 16'h5A96, 0);
    run_command(xfer_pkg::CMD_COPY, bus_pkg::BUS_SIZE_BYTE, 16'h3000, 16'h3003, 16'd10, 16'h0, 0);
    verify_range(16'h3000, 16, bus_pkg::BUS_SIZE_BYTE);
    run_command(xfer_pkg::CMD_COPY, bus_pkg::BUS_SIZE_WORD, 16'h2FFE, 16'h3000, 16'd9, 16'h0, 0);
    verify_range(16'h2FFE, 12, bus_pkg::BUS_SIZE_WORD);
    run_command(xfer_pkg::CMD_COPY, bus_pkg::BUS_SIZE_WORD, 16'h3000, 16'h3800, 16'd0, 16'h0, 0);
    run_command(xfer_pkg::CMD_FILL, bus_pkg::BUS_SIZE_BYTE, 16'h0, 16'h3800, 16'd0, 16'hFFFF, 0);
    verify_range(16'h3800, 2, bus_pkg::BUS_SIZE_WORD);

    // host keeps cmd_req high past cmd_ack
    run_command(xfer_pkg::CMD_FILL, bus_pkg::BUS_SIZE_WORD, 16'h0, 16'h5000, 16'd6, 16'h0F0F, 5);
    run_command(xfer_pkg::CMD_READ, bus_pkg::BUS_SIZE_WORD, 16'h5004, 16'h0, 16'd1, 16'h0, 3);
    run_command(xfer_pkg::CMD_READ, bus_pkg::BUS_SIZE_BYTE, 16'h500B, 16'h0, 16'd1, 16'h0, 0);

    for (int n = 0; n < 200; n++) begin
      r = next_random();
      rc = xfer_pkg::cmd_t'(r[1:0]);
      rs = bus_pkg::bus_size_t'(r[2]);
      run_command(rc, rs, 16'h4000 + next_random() % 256, 16'h4000 + next_random() % 256,
                  16'd1 + next_random() % 40, next_random(), 0);
    end

    drain = 0;
    while (kind_q.size() > 0 && drain < 10) begin
      @(negedge clk);
      drain++;
    end
    if (kind_q.size() == 0 && errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("results were left unchecked at the end of the run");
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== mem_subsys.f ====
+incdir+.
bus_pkg.sv
xfer_pkg.sv
mem_unit.sv
addr_gen.sv
data_stage.sv
xfer_ctrl.sv
mem_subsys.sv
tb_mem_subsys.sv
